//--- src.f
dcache_pkg.sv
dcache_tag.sv
dcache_data.sv
dcache_ctrl.sv
dcache_top.sv
dcache_asserts.sv
tb_dcache.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

    logic              clk_i;
    logic              rst_n_i;
    logic              req_i;
    logic              we_i;
    logic              word_i;
    logic [ADDR_W-1:0] addr_i;
    logic [31:0]       wdata_i;
    logic              flush_i;
    logic              ready_o;
    logic [31:0]       rdata_o;
    logic              mem_rd_o;
    logic [ADDR_W-1:0] mem_addr_o;
    logic              mem_valid_i;
    line_t             mem_line_i;
    logic              mem_wr_o;
    logic              mem_word_o;
    logic [31:0]       mem_wdata_o;

    logic [7:0]        mem [1024];
    logic [7:0]        shadow [1024];
    int                seed = 32'hf205;
    int                num_accesses = 45;
    int                rd_count = 0;
    int                wr_count = 0;
    logic [ADDR_W-1:0] last_wr_addr;
    logic [31:0]       last_wr_data;
    logic              last_wr_word;
    int                errors = 0;
    int                tests_run = 0;
    int                tests_failed = 0;
    int                test_base = 0;
    string             cur_test;

    dcache_top DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // the memory counts line reads and applies every write-through strobe.
    always @(posedge clk_i) begin
        if (rst_n_i && mem_rd_o) begin
            rd_count++;
        end
        if (rst_n_i && mem_wr_o) begin
            wr_count++;
            last_wr_addr = mem_addr_o;
            last_wr_data = mem_wdata_o;
            last_wr_word = mem_word_o;
            if (mem_word_o) begin
                for (int b = 0; b < 4; b++) begin
                    mem[{mem_addr_o[9:2], 2'b00} + 10'(b)] = mem_wdata_o[8*b +: 8];
                end
            end else begin
                mem[mem_addr_o[9:0]] = mem_wdata_o[7:0];
            end
        end
    end

    // line reads are answered after a random 1 to 6 cycles.
    initial begin
        logic [ADDR_W-1:0] rd_addr;
        line_t             line;
        int                delay;
        mem_valid_i = 1'b0;
        mem_line_i  = '0;
        forever begin
            @(posedge clk_i);
            if (rst_n_i && mem_rd_o) begin
                rd_addr = mem_addr_o;
                delay   = 1 + int'($unsigned($random(seed)) % 32'd6);
                for (int b = 0; b < 16; b++) begin
                    line.bytes[b] = mem[rd_addr[9:0] + 10'(b)];
                end
                repeat (delay) @(negedge clk_i);
                mem_line_i  = line;
                mem_valid_i = 1'b1;
                @(negedge clk_i);
                mem_valid_i = 1'b0;
            end
        end
    end

    function automatic int total_errors();
        return errors + DUT.u_asserts.fail_count;
    endfunction

    function automatic logic [31:0] expected_load(input logic word, input logic [ADDR_W-1:0] addr);
        logic [9:0] a;
        a = addr[9:0];
        if (word) begin
            a[1:0] = 2'b00;
            return {shadow[a + 10'd3], shadow[a + 10'd2], shadow[a + 10'd1], shadow[a]};
        end
        return {24'd0, shadow[a]};
    endfunction

    // one request, held until ready_o, then one idle cycle.
    task automatic access(input logic we, input logic word, input logic [ADDR_W-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata);
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        req_i   = 1'b1;
        we_i    = we;
        word_i  = word;
        addr_i  = addr;
        wdata_i = wdata;
        #5;
        while (!ready_o && cycles < 20) begin
            @(negedge clk_i);
            #5;
            cycles++;
        end
        if (!ready_o) begin
            $display("test %s: no ready_o within 20 cycles for address %h", cur_test, addr);
            errors++;
        end
        rdata = rdata_o;
        @(negedge clk_i);
        req_i  = 1'b0;
        we_i   = 1'b0;
        word_i = 1'b0;
    endtask

    task automatic check_load(input logic [ADDR_W-1:0] addr, input logic word, input int reads);
        logic [31:0] got;
        logic [31:0] exp;
        int          rd_before;
        rd_before = rd_count;
        access(1'b0, word, addr, 32'd0, got);
        exp = expected_load(word, addr);
        assert (got == exp) else begin
            $display("CHECK FAILED %s: load %h expected %h actual %h", cur_test, addr, exp, got);
            errors++;
        end
        assert (rd_count - rd_before == reads) else begin
            $display("CHECK FAILED %s: line reads for %h expected %0d actual %0d",
                     cur_test, addr, reads, rd_count - rd_before);
            errors++;
        end
    endtask

    task automatic check_store(input logic [ADDR_W-1:0] addr, input logic word,
                               input logic [31:0] data);
        logic [31:0] unused;
        logic [9:0]  a;
        int          rd_before;
        int          wr_before;
        rd_before = rd_count;
        wr_before = wr_count;
        access(1'b1, word, addr, data, unused);
        a = addr[9:0];
        if (word) begin
            for (int b = 0; b < 4; b++) begin
                shadow[{a[9:2], 2'b00} + 10'(b)] = data[8*b +: 8];
            end
        end else begin
            shadow[a] = data[7:0];
        end
        assert (wr_count - wr_before == 1) else begin
            $display("CHECK FAILED %s: write strobes expected 1 actual %0d",
                     cur_test, wr_count - wr_before);
            errors++;
        end
        assert (last_wr_addr == addr) else begin
            $display("CHECK FAILED %s: write address expected %h actual %h",
                     cur_test, addr, last_wr_addr);
            errors++;
        end
        assert (last_wr_word == word) else begin
            $display("CHECK FAILED %s: write word flag expected %0d actual %0d",
                     cur_test, word, last_wr_word);
            errors++;
        end
        assert (last_wr_data == data) else begin
            $display("CHECK FAILED %s: write data expected %h actual %h",
                     cur_test, data, last_wr_data);
            errors++;
        end
        assert (rd_count == rd_before) else begin
            $display("CHECK FAILED %s: line reads on store expected 0 actual %0d",
                     cur_test, rd_count - rd_before);
            errors++;
        end
    endtask

    task automatic flush_cache();
        @(negedge clk_i);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_base = total_errors();
    endtask

    task automatic end_test();
        int n;
        n = total_errors() - test_base;
        tests_run++;
        if (n == 0) begin
            $display("test %s: pass", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", cur_test, n);
        end
    endtask

    initial begin
        rst_n_i = 1'b0;
        req_i   = 1'b0;
        we_i    = 1'b0;
        word_i  = 1'b0;
        addr_i  = '0;
        wdata_i = '0;
        flush_i = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            mem[i]    = 8'($random(seed));
            shadow[i] = mem[i];
        end
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        begin_test("cold_miss_hit");
        check_load(32'h040, 1'b1, 1);
        check_load(32'h047, 1'b0, 0);
        end_test();

        begin_test("byte_word_loads");
        for (int w = 0; w < 4; w++) begin
            check_load(32'h080 + 32'(4 * w), 1'b1, (w == 0) ? 1 : 0);
        end
        for (int b = 0; b < 16; b++) begin
            check_load(32'h080 + 32'(b), 1'b0, 0);
        end
        end_test();

        begin_test("store_hit");
        check_load(32'h0c0, 1'b1, 1);
        check_store(32'h0c4, 1'b1, 32'($random(seed)));
        check_load(32'h0c4, 1'b1, 0);
        check_store(32'h0c9, 1'b0, 32'($random(seed)));
        check_load(32'h0c9, 1'b0, 0);
        check_load(32'h0c8, 1'b1, 0);
        end_test();

        begin_test("store_miss");
        check_store(32'h204, 1'b1, 32'($random(seed)));
        check_load(32'h204, 1'b1, 1);
        end_test();

        // five new lines wrap the victim pointer onto the lane of the first.
        begin_test("round_robin");
        for (int l = 0; l < 5; l++) begin
            check_load(32'h300 + 32'(16 * l), 1'b1, 1);
        end
        // only the first line was evicted, the other four still hit.
        for (int l = 1; l < 5; l++) begin
            check_load(32'h300 + 32'(16 * l), 1'b1, 0);
        end
        check_load(32'h300, 1'b1, 1);
        end_test();

        begin_test("invalidate");
        check_load(32'h320, 1'b1, 0);
        flush_cache();
        check_load(32'h340, 1'b1, 1);
        check_load(32'h300, 1'b1, 1);
        check_load(32'h320, 1'b1, 1);
        check_load(32'h330, 1'b1, 1);
        end_test();

        $display("tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 tests_run, tests_run - tests_failed, tests_failed, total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        repeat (num_accesses * 20 + 1000) @(posedge clk_i);
        $display("watchdog expired, the run did not finish in time");
        $display("tests failed");
        $finish;
    end

endmodule : tb_dcache

//--- dcache_asserts.sv
`timescale 1ns/1ps

module dcache_asserts import dcache_pkg::*; (
    input logic clk_i,
    input logic rst_n_i,
    input logic req_i,
    input logic ready_i,
    input logic mem_rd_i,
    input logic mem_wr_i,
    input logic hit_i
);

    int fail_count = 0;

    // a completion never appears without a request behind it.
    ready_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ready_i |-> req_i)
        else begin
            $error("ready_o seen without req_i");
            fail_count = fail_count + 1;
        end

    rd_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_rd_i |=> !mem_rd_i)
        else begin
            $error("mem_rd_o held for more than one cycle");
            fail_count = fail_count + 1;
        end

    wr_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_wr_i |=> !mem_wr_i)
        else begin
            $error("mem_wr_o held for more than one cycle");
            fail_count = fail_count + 1;
        end

    no_read_on_hit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_rd_i |-> !hit_i)
        else begin
            $error("mem_rd_o issued while the request hits");
            fail_count = fail_count + 1;
        end

    quiet_after_reset: assert property (@(posedge clk_i)
        !rst_n_i |=> (!ready_i && !mem_rd_i && !mem_wr_i))
        else begin
            $error("control outputs active in the cycle after reset");
            fail_count = fail_count + 1;
        end

endmodule : dcache_asserts

bind dcache_top dcache_asserts u_asserts (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (req_i),
    .ready_i  (ready_o),
    .mem_rd_i (mem_rd_o),
    .mem_wr_i (mem_wr_o),
    .hit_i    (hit)
);

//--- dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              req_i,
    input  logic              we_i,
    input  logic              word_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [31:0]       wdata_i,
    input  logic              flush_i,
    output logic              ready_o,
    output logic [31:0]       rdata_o,
    output logic              mem_rd_o,
    output logic [ADDR_W-1:0] mem_addr_o,
    input  logic              mem_valid_i,
    input  line_t             mem_line_i,
    output logic              mem_wr_o,
    output logic              mem_word_o,
    output logic [31:0]       mem_wdata_o
);

    logic [TAG_W-1:0]    tag;
    logic [OFFSET_W-1:0] offset;
    logic                hit;
    logic                miss;
    logic [LANE_W-1:0]   hit_lane;
    logic                fill;
    logic [LANE_W-1:0]   fill_lane;
    logic                store_hit;

    assign tag    = addr_i[ADDR_W-1:OFFSET_W];
    assign offset = addr_i[OFFSET_W-1:0];

    // line reads go out line-aligned, write strobes carry the byte address.
    assign mem_addr_o  = mem_rd_o ? {tag, {OFFSET_W{1'b0}}} : addr_i;
    assign mem_word_o  = word_i;
    assign mem_wdata_o = wdata_i;

    dcache_tag u_tag (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .tag_i        (tag),
        .fill_i       (fill),
        .fill_lane_i  (fill_lane),
        .invalidate_i (flush_i),
        .hit_o        (hit),
        .miss_o       (miss),
        .hit_lane_o   (hit_lane)
    );

    dcache_data u_data (
        .clk_i       (clk_i),
        .fill_i      (fill),
        .fill_lane_i (fill_lane),
        .fill_line_i (mem_line_i),
        .store_i     (store_hit),
        .lane_i      (hit_lane),
        .offset_i    (offset),
        .word_i      (word_i),
        .wdata_i     (wdata_i),
        .rdata_o     (rdata_o)
    );

    dcache_ctrl u_ctrl (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .we_i        (we_i),
        .hit_i       (hit),
        .miss_i      (miss),
        .mem_valid_i (mem_valid_i),
        .ready_o     (ready_o),
        .store_hit_o (store_hit),
        .fill_o      (fill),
        .fill_lane_o (fill_lane),
        .mem_rd_o    (mem_rd_o),
        .mem_wr_o    (mem_wr_o)
    );

endmodule : dcache_top

//--- dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              req_i,
    input  logic              we_i,
    input  logic              hit_i,
    input  logic              miss_i,
    input  logic              mem_valid_i,
    output logic              ready_o,
    output logic              store_hit_o,
    output logic              fill_o,
    output logic [LANE_W-1:0] fill_lane_o,
    output logic              mem_rd_o,
    output logic              mem_wr_o
);

    logic [1:0]        state_q;
    logic [1:0]        state_d;
    logic [LANE_W-1:0] victim_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // round-robin victim, moved on by one after every fill.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            victim_q <= '0;
        end else if (fill_o) begin
            victim_q <= victim_q + 1'b1;
        end
    end

    assign fill_lane_o = victim_q;

    always_comb begin
        state_d     = state_q;
        ready_o     = 1'b0;
        store_hit_o = 1'b0;
        fill_o      = 1'b0;
        mem_rd_o    = 1'b0;
        mem_wr_o    = 1'b0;

        case (state_q)
            ST_IDLE: begin
                if (req_i && we_i) begin
                    // write-through; the local copy is only touched on a hit.
                    ready_o     = 1'b1;
                    mem_wr_o    = 1'b1;
                    store_hit_o = hit_i;
                end else if (hit_i) begin
                    ready_o = 1'b1;
                end else if (miss_i) begin
                    state_d = ST_ISSUE;
                end
            end
            ST_ISSUE: begin
                mem_rd_o = 1'b1;
                state_d  = ST_WAIT;
            end
            ST_WAIT: begin
                // the refilled line turns the held request into a hit next cycle.
                if (mem_valid_i) begin
                    fill_o  = 1'b1;
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

endmodule : dcache_ctrl

//--- dcache_data.sv
`timescale 1ns/1ps

module dcache_data import dcache_pkg::*; (
    input  logic                clk_i,
    input  logic                fill_i,
    input  logic [LANE_W-1:0]   fill_lane_i,
    input  line_t               fill_line_i,
    input  logic                store_i,
    input  logic [LANE_W-1:0]   lane_i,
    input  logic [OFFSET_W-1:0] offset_i,
    input  logic                word_i,
    input  logic [31:0]         wdata_i,
    output logic [31:0]         rdata_o
);

    line_t lines [NUM_LANES];
    line_t rd_line;
    logic [OFFSET_W-3:0] word_idx;

    // word accesses are aligned, so the low two offset bits are ignored.
    assign word_idx = offset_i[OFFSET_W-1:2];

    // a fill and a store hit never happen in the same cycle.
    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            lines[fill_lane_i] <= fill_line_i;
        end else if (store_i) begin
            if (word_i) begin
                lines[lane_i].words[word_idx] <= wdata_i;
            end else begin
                lines[lane_i].bytes[offset_i] <= wdata_i[7:0];
            end
        end
    end

    assign rd_line = lines[lane_i];

    // byte loads come back zero-extended.
    always_comb begin
        if (word_i) begin
            rdata_o = rd_line.words[word_idx];
        end else begin
            rdata_o = {24'd0, rd_line.bytes[offset_i]};
        end
    end

endmodule : dcache_data

//--- dcache_tag.sv
`timescale 1ns/1ps

module dcache_tag import dcache_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              req_i,
    input  logic [TAG_W-1:0]  tag_i,
    input  logic              fill_i,
    input  logic [LANE_W-1:0] fill_lane_i,
    input  logic              invalidate_i,
    output logic              hit_o,
    output logic              miss_o,
    output logic [LANE_W-1:0] hit_lane_o
);

    logic [NUM_LANES-1:0] valid_q;
    logic [TAG_W-1:0]     tag_q [NUM_LANES];
    logic [NUM_LANES-1:0] match;
    logic                 any_match;

    // invalidate takes priority over a fill in the same cycle.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (invalidate_i) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[fill_lane_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tag_q[fill_lane_i] <= tag_i;
        end
    end

    // every lane is compared at once; at most one can match.
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            match[i] = valid_q[i] && (tag_q[i] == tag_i);
        end
        any_match = |match;
    end

    always_comb begin
        hit_lane_o = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (match[i]) begin
                hit_lane_o = LANE_W'(i);
            end
        end
    end

    assign hit_o  = req_i && any_match;
    assign miss_o = req_i && !any_match;

endmodule : dcache_tag

//--- dcache_pkg.sv
package dcache_pkg;

    // cache geometry.
    localparam int ADDR_W         = 32;
    localparam int OFFSET_W       = 4;
    localparam int TAG_W          = ADDR_W - OFFSET_W;
    localparam int NUM_LANES      = 4;
    localparam int LANE_W         = 2;
    localparam int WORDS_PER_LINE = 4;

    // miss FSM encodings.
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_ISSUE = 2'd1;
    localparam logic [1:0] ST_WAIT  = 2'd2;

    // one cache line, read either as bytes or as 32-bit words.
    typedef union packed {
        logic [WORDS_PER_LINE*4-1:0][7:0] bytes;
        logic [WORDS_PER_LINE-1:0][31:0]  words;
    } line_t;

endpackage : dcache_pkg
